// ==== rtl/mcu_decode.sv ====
// ****************************************
// fetch sequencer of the MCU core
// reads 1 to 3 bytes from program ROM,
// emits one decoded instruction and idles
// until result redirects the PC
// ****************************************

module mcu_decode (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       cen_i,
    input  logic [7:0]                 rom_data_i,
    input  logic                       redirect_i,
    input  logic [15:0]                redirect_pc_i,
    output logic [mcu_pkg::ROM_AW-1:0] rom_addr_o,
    output mcu_pkg::instr_t            instr_o,
    output logic                       instr_vld_o
);
    import mcu_pkg::*;

    typedef enum logic [2:0] {ST_ADDR, ST_B0, ST_B1, ST_B2, ST_WAIT} state_e;

    state_e      state;
    logic [15:0] fetch_pc;
    logic [1:0]  len_q;
    op_e         dec_op;
    logic [1:0]  dec_len;

    // opcode byte to op and length
    always_comb begin
        dec_len = 2'd2;
        case (rom_data_i)
            OPC_MOV_A_IMM:   dec_op = OP_MOV_A_IMM;
            OPC_MOV_A_DIR:   dec_op = OP_MOV_A_DIR;
            OPC_MOV_DIR_A:   dec_op = OP_MOV_DIR_A;
            OPC_ADD_IMM:     dec_op = OP_ADD_IMM;
            OPC_ADD_DIR:     dec_op = OP_ADD_DIR;
            OPC_ANL_IMM:     dec_op = OP_ANL_IMM;
            OPC_ORL_IMM:     dec_op = OP_ORL_IMM;
            OPC_XRL_IMM:     dec_op = OP_XRL_IMM;
            OPC_SJMP:        dec_op = OP_SJMP;
            OPC_JZ:          dec_op = OP_JZ;
            OPC_JNZ:         dec_op = OP_JNZ;
            OPC_MOV_DIR_IMM: begin
                dec_op  = OP_MOV_DIR_IMM;
                dec_len = 2'd3;
            end
            OPC_MOV_DPTR: begin
                dec_op  = OP_MOV_DPTR;
                dec_len = 2'd3;
            end
            OPC_INC_A: begin
                dec_op  = OP_INC_A;
                dec_len = 2'd1;
            end
            OPC_MOVX_RD: begin
                dec_op  = OP_MOVX_RD;
                dec_len = 2'd1;
            end
            OPC_MOVX_WR: begin
                dec_op  = OP_MOVX_WR;
                dec_len = 2'd1;
            end
            // unknown opcodes run as NOP
            default: begin
                dec_op  = OP_NOP;
                dec_len = 2'd1;
            end
        endcase
    end

    // redirect target goes straight to the ROM, saves a cycle
    assign rom_addr_o = (state == ST_WAIT && redirect_i) ? redirect_pc_i[ROM_AW-1:0]
                                                        : fetch_pc[ROM_AW-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state       <= ST_ADDR;
            fetch_pc    <= '0;
            len_q       <= 2'd1;
            instr_vld_o <= 1'b0;
        end else if (cen_i) begin
            instr_vld_o <= 1'b0;
            case (state)
                ST_ADDR: begin
                    fetch_pc <= fetch_pc + 16'd1;
                    state    <= ST_B0;
                end
                ST_B0: begin
                    len_q <= dec_len;
                    if (dec_len == 2'd1) begin
                        instr_vld_o <= 1'b1;
                        state       <= ST_WAIT;
                    end else begin
                        fetch_pc <= fetch_pc + 16'd1;
                        state    <= ST_B1;
                    end
                end
                ST_B1: begin
                    if (len_q == 2'd2) begin
                        instr_vld_o <= 1'b1;
                        state       <= ST_WAIT;
                    end else begin
                        fetch_pc <= fetch_pc + 16'd1;
                        state    <= ST_B2;
                    end
                end
                ST_B2: begin
                    instr_vld_o <= 1'b1;
                    state       <= ST_WAIT;
                end
                default: begin
                    // ROM already holds the byte at redirect_pc
                    if (redirect_i) begin
                        fetch_pc <= redirect_pc_i + 16'd1;
                        state    <= ST_B0;
                    end
                end
            endcase
        end
    end

    // fetch_pc always points one past the last byte taken
    always_ff @(posedge clk) begin
        if (cen_i) begin
            case (state)
                ST_B0: begin
                    instr_o.op      <= dec_op;
                    instr_o.next_pc <= fetch_pc;
                end
                ST_B1: begin
                    instr_o.b1      <= rom_data_i;
                    instr_o.next_pc <= fetch_pc;
                end
                ST_B2: begin
                    instr_o.b2      <= rom_data_i;
                    instr_o.next_pc <= fetch_pc;
                end
                default: ;
            endcase
        end
    end

    // one instruction in flight
    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n_i)
        cen_i && instr_vld_o |=> !(cen_i && instr_vld_o) until redirect_i);

    // programs stay inside the 4 KB ROM
    a_pc_in_rom: assert property (@(posedge clk) disable iff (!rst_n_i)
        cen_i |-> fetch_pc[15:ROM_AW] == '0);

endmodule

// ==== rtl/mcu_execute.sv ====
// ****************************************
// execute stage of the MCU core
// operand select, ALU, branch target and
// MOVX strobes, one instruction at a time
// ****************************************

module mcu_execute (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       cen_i,
    input  mcu_pkg::instr_t            instr_i,
    input  logic                       instr_vld_i,
    input  logic [7:0]                 acc_i,
    input  logic                       carry_i,
    input  logic [15:0]                dptr_i,
    input  logic [7:0]                 p0_i,
    input  logic [7:0]                 p1_latch_i,
    input  logic [7:0]                 ram_q_i,
    input  logic [7:0]                 x_din_i,
    output logic [mcu_pkg::RAM_AW-1:0] ram_addr_o,
    output mcu_pkg::exec_t             exec_o,
    output logic                       exec_vld_o,
    output mcu_pkg::xbus_t             xbus_o
);
    import mcu_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_EXEC} state_e;

    state_e      state;
    instr_t      ir;
    logic [7:0]  dir_val;
    logic [7:0]  opnd;
    logic [8:0]  sum;
    logic [15:0] target;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= ST_IDLE;
        end else if (cen_i) begin
            case (state)
                ST_IDLE: begin
                    // RAM and external reads need a cycle for data
                    if (instr_vld_i) begin
                        state <= (instr_i.op inside {OP_MOV_A_DIR, OP_ADD_DIR, OP_MOVX_RD})
                                 ? ST_WAIT : ST_EXEC;
                    end
                end
                ST_WAIT: state <= ST_EXEC;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cen_i && instr_vld_i && state == ST_IDLE) begin
            ir <= instr_i;
        end
    end

    // also the write address at commit
    assign ram_addr_o = ir.b1[RAM_AW-1:0];
    assign exec_vld_o = (state == ST_EXEC);

    always_comb begin
        // direct source, unmapped SFRs read 0
        if (ir.b1 == SFR_P0) begin
            dir_val = p0_i;
        end else if (ir.b1 == SFR_P1) begin
            dir_val = p1_latch_i;
        end else if (!ir.b1[7]) begin
            dir_val = ram_q_i;
        end else begin
            dir_val = 8'h00;
        end
        opnd   = (ir.op == OP_ADD_DIR) ? dir_val : ir.b1;
        sum    = {1'b0, acc_i} + {1'b0, opnd};
        target = ir.next_pc + {{8{ir.b1[7]}}, ir.b1};

        exec_o          = '0;
        exec_o.op       = ir.op;
        exec_o.carry    = carry_i;
        exec_o.dir_addr = ir.b1;
        exec_o.dptr_val = {ir.b1, ir.b2};
        case (ir.op)
            OP_MOV_A_IMM:   exec_o.value = ir.b1;
            OP_MOV_A_DIR:   exec_o.value = dir_val;
            OP_MOV_DIR_A:   exec_o.value = acc_i;
            OP_MOV_DIR_IMM: exec_o.value = ir.b2;
            OP_ANL_IMM:     exec_o.value = acc_i & ir.b1;
            OP_ORL_IMM:     exec_o.value = acc_i | ir.b1;
            OP_XRL_IMM:     exec_o.value = acc_i ^ ir.b1;
            // carry untouched on INC
            OP_INC_A:       exec_o.value = acc_i + 8'd1;
            OP_MOVX_RD:     exec_o.value = x_din_i;
            OP_ADD_IMM, OP_ADD_DIR: begin
                exec_o.value = sum[7:0];
                exec_o.carry = sum[8];
            end
            default:        exec_o.value = 8'h00;
        endcase
        exec_o.wr_a        = ir.op inside {OP_MOV_A_IMM, OP_MOV_A_DIR, OP_ADD_IMM,
                                           OP_ADD_DIR, OP_ANL_IMM, OP_ORL_IMM,
                                           OP_XRL_IMM, OP_INC_A, OP_MOVX_RD};
        exec_o.wr_dir      = ir.op inside {OP_MOV_DIR_A, OP_MOV_DIR_IMM};
        exec_o.wr_dptr     = (ir.op == OP_MOV_DPTR);
        exec_o.take_branch = (ir.op == OP_SJMP)
                             || (ir.op == OP_JZ && acc_i == 8'h00)
                             || (ir.op == OP_JNZ && acc_i != 8'h00);
        exec_o.new_pc      = exec_o.take_branch ? target : ir.next_pc;
    end

    // MOVX strobes, one clk wide
    always_comb begin
        xbus_o.addr = dptr_i;
        xbus_o.dout = acc_i;
        xbus_o.wr   = cen_i && state == ST_EXEC && ir.op == OP_MOVX_WR;
        xbus_o.acc  = xbus_o.wr || (cen_i && state == ST_WAIT && ir.op == OP_MOVX_RD);
    end

    // decode hands over only to an idle execute stage
    a_instr_when_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        cen_i && instr_vld_i |-> state == ST_IDLE);

endmodule

// ==== rtl/mcu_iram.sv ====
// ****************************************
// 128-byte internal data RAM
// read and write only on the clock enable
// a write also returns the written byte
// ****************************************

module mcu_iram (
    input  logic                       clk,
    input  logic                       cen_i,
    input  logic [mcu_pkg::RAM_AW-1:0] addr_i,
    input  logic [7:0]                 din_i,
    input  logic                       we_i,
    output logic [7:0]                 q_o
);
    import mcu_pkg::*;

    logic [7:0] mem [2**RAM_AW];

    always_ff @(posedge clk) begin
        if (cen_i) begin
            if (we_i) begin
                mem[addr_i] <= din_i;
                // write-through keeps q coherent
                q_o <= din_i;
            end else begin
                q_o <= mem[addr_i];
            end
        end
    end

endmodule

// ==== rtl/mcu_pkg.sv ====
// ****************************************
// shared definitions for the 8051-subset MCU
// opcode bytes, SFR addresses, op codes and
// the structs passed between core stages
// import inside each module body
// ****************************************

package mcu_pkg;

    // program ROM is 4 KB, internal RAM 128 bytes
    localparam int ROM_AW = 12;
    localparam int RAM_AW = 7;

    // direct addresses mapped to ports
    localparam logic [7:0] SFR_P0 = 8'h80;
    localparam logic [7:0] SFR_P1 = 8'h90;

    // 8051 opcode bytes of the supported subset
    localparam logic [7:0] OPC_NOP         = 8'h00;
    localparam logic [7:0] OPC_INC_A       = 8'h04;
    localparam logic [7:0] OPC_ADD_IMM     = 8'h24;
    localparam logic [7:0] OPC_ADD_DIR     = 8'h25;
    localparam logic [7:0] OPC_ORL_IMM     = 8'h44;
    localparam logic [7:0] OPC_ANL_IMM     = 8'h54;
    localparam logic [7:0] OPC_JZ          = 8'h60;
    localparam logic [7:0] OPC_XRL_IMM     = 8'h64;
    localparam logic [7:0] OPC_JNZ         = 8'h70;
    localparam logic [7:0] OPC_MOV_A_IMM   = 8'h74;
    localparam logic [7:0] OPC_MOV_DIR_IMM = 8'h75;
    localparam logic [7:0] OPC_SJMP        = 8'h80;
    localparam logic [7:0] OPC_MOV_DPTR    = 8'h90;
    localparam logic [7:0] OPC_MOVX_RD     = 8'hE0;
    localparam logic [7:0] OPC_MOV_A_DIR   = 8'hE5;
    localparam logic [7:0] OPC_MOVX_WR     = 8'hF0;
    localparam logic [7:0] OPC_MOV_DIR_A   = 8'hF5;

    typedef enum logic [4:0] {
        OP_NOP, OP_MOV_A_IMM, OP_MOV_A_DIR, OP_MOV_DIR_A, OP_MOV_DIR_IMM,
        OP_ADD_IMM, OP_ADD_DIR, OP_ANL_IMM, OP_ORL_IMM, OP_XRL_IMM,
        OP_INC_A, OP_MOV_DPTR, OP_MOVX_RD, OP_MOVX_WR, OP_SJMP, OP_JZ, OP_JNZ
    } op_e;

    // decoded instruction, 37 bits
    typedef struct packed {
        op_e         op;
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [15:0] next_pc;
    } instr_t;

    // execute to result
    typedef struct packed {
        op_e         op;
        logic [7:0]  value;
        logic        carry;
        logic        wr_a;
        logic        wr_dir;
        logic        wr_dptr;
        logic        take_branch;
        logic [7:0]  dir_addr;
        logic [15:0] dptr_val;
        logic [15:0] new_pc;
    } exec_t;

    // external data bus, 26 bits
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        wr;
        logic        acc;
    } xbus_t;

endpackage

// ==== rtl/mcu_prog_rom.sv ====
// ****************************************
// program memory with two clocks
// loader writes on clk_rom_i while the core
// is in reset, core reads on clk with cen
// ****************************************

module mcu_prog_rom (
    input  logic                       clk_rom_i,
    input  logic                       prog_we_i,
    input  logic [mcu_pkg::ROM_AW-1:0] prog_addr_i,
    input  logic [7:0]                 prog_din_i,
    input  logic                       clk,
    input  logic                       cen_i,
    input  logic [mcu_pkg::ROM_AW-1:0] rd_addr_i,
    output logic [7:0]                 rd_data_o
);
    import mcu_pkg::*;

    logic [7:0] mem [2**ROM_AW];

    // loader side
    always_ff @(posedge clk_rom_i) begin
        if (prog_we_i) begin
            mem[prog_addr_i] <= prog_din_i;
        end
    end

    // core side, data valid one enabled cycle later
    always_ff @(posedge clk) begin
        if (cen_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// ==== rtl/mcu_result.sv ====
// ****************************************
// architectural state of the MCU core
// commits A, carry, DPTR, P1 and RAM writes
// then redirects fetch to the next PC
// ****************************************

module mcu_result (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           cen_i,
    input  mcu_pkg::exec_t exec_i,
    input  logic           exec_vld_i,
    output logic [7:0]     acc_o,
    output logic           carry_o,
    output logic [15:0]    dptr_o,
    output logic [7:0]     p1_o,
    output logic           ram_we_o,
    output logic [7:0]     ram_din_o,
    output logic           redirect_o,
    output logic [15:0]    redirect_pc_o
);
    import mcu_pkg::*;

    // direct writes below 0x80 land in RAM
    assign ram_we_o  = exec_vld_i && exec_i.wr_dir && !exec_i.dir_addr[7];
    assign ram_din_o = exec_i.value;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            acc_o      <= 8'h00;
            carry_o    <= 1'b0;
            dptr_o     <= 16'h0000;
            p1_o       <= 8'hFF;
            redirect_o <= 1'b0;
        end else if (cen_i) begin
            redirect_o <= exec_vld_i;
            if (exec_vld_i) begin
                carry_o <= exec_i.carry;
                if (exec_i.wr_a) begin
                    acc_o <= exec_i.value;
                end
                if (exec_i.wr_dptr) begin
                    dptr_o <= exec_i.dptr_val;
                end
                // other SFR writes are dropped
                if (exec_i.wr_dir && exec_i.dir_addr == SFR_P1) begin
                    p1_o <= exec_i.value;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen_i && exec_vld_i) begin
            redirect_pc_o <= exec_i.new_pc;
        end
    end

    // only jumps may leave the sequential path
    a_branch_op: assert property (@(posedge clk) disable iff (!rst_n_i)
        exec_vld_i && exec_i.take_branch |-> exec_i.op inside {OP_SJMP, OP_JZ, OP_JNZ});

endmodule

// ==== rtl/mcu_top.sv ====
// ****************************************
// 8051-subset MCU for arcade sub-CPU use
// program loaded through clk_rom_i in reset
// DIV_CEN=1 runs the core at cen_i / 12
// external bus outputs lag the core by a clk
// ****************************************

module mcu_top #(
    parameter bit DIV_CEN = 1'b0,
    parameter bit SYNC_P0 = 1'b1
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       cen_i,
    input  logic [7:0]                 p0_i,
    input  logic [7:0]                 x_din_i,
    input  logic                       clk_rom_i,
    input  logic                       prog_we_i,
    input  logic [mcu_pkg::ROM_AW-1:0] prog_addr_i,
    input  logic [7:0]                 prog_din_i,
    output logic [7:0]                 p1_o,
    output logic [15:0]                x_addr_o,
    output logic [7:0]                 x_dout_o,
    output logic                       x_wr_o,
    output logic                       x_acc_o
);
    import mcu_pkg::*;

    logic [3:0]        div_cnt;
    logic              cen_div;
    logic              cen_eff;
    logic [7:0]        p0_s;
    logic [ROM_AW-1:0] rom_addr;
    logic [7:0]        rom_data;
    logic [RAM_AW-1:0] ram_addr;
    logic [7:0]        ram_q;
    logic [7:0]        ram_din;
    logic              ram_we;
    instr_t            instr;
    logic              instr_vld;
    exec_t             exec;
    logic              exec_vld;
    xbus_t             xbus;
    xbus_t             xbus_q;
    logic [7:0]        acc;
    logic              carry;
    logic [15:0]       dptr;
    logic              redirect;
    logic [15:0]       redirect_pc;

    // divide-by-12 enable
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            div_cnt <= 4'd0;
            cen_div <= 1'b0;
        end else begin
            if (cen_i) begin
                div_cnt <= (div_cnt == 4'd11) ? 4'd0 : div_cnt + 4'd1;
            end
            cen_div <= cen_i && div_cnt == 4'd11;
        end
    end

    assign cen_eff = DIV_CEN ? cen_div : cen_i;

    // port 0 sampled on the core enable
    always_ff @(posedge clk) begin
        if (cen_eff) begin
            p0_s <= p0_i;
        end
    end

    // bus pins registered, strobes cleared in reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            xbus_q <= '0;
        end else begin
            xbus_q <= xbus;
        end
    end

    assign x_addr_o = xbus_q.addr;
    assign x_dout_o = xbus_q.dout;
    assign x_wr_o   = xbus_q.wr;
    assign x_acc_o  = xbus_q.acc;

    mcu_prog_rom u_rom (
        .clk_rom_i   ( clk_rom_i   ),
        .prog_we_i   ( prog_we_i   ),
        .prog_addr_i ( prog_addr_i ),
        .prog_din_i  ( prog_din_i  ),
        .clk         ( clk         ),
        .cen_i       ( cen_eff     ),
        .rd_addr_i   ( rom_addr    ),
        .rd_data_o   ( rom_data    )
    );

    mcu_iram u_iram (
        .clk    ( clk      ),
        .cen_i  ( cen_eff  ),
        .addr_i ( ram_addr ),
        .din_i  ( ram_din  ),
        .we_i   ( ram_we   ),
        .q_o    ( ram_q    )
    );

    mcu_decode u_decode (
        .clk           ( clk         ),
        .rst_n_i       ( rst_n_i     ),
        .cen_i         ( cen_eff     ),
        .rom_data_i    ( rom_data    ),
        .redirect_i    ( redirect    ),
        .redirect_pc_i ( redirect_pc ),
        .rom_addr_o    ( rom_addr    ),
        .instr_o       ( instr       ),
        .instr_vld_o   ( instr_vld   )
    );

    mcu_execute u_execute (
        .clk         ( clk                    ),
        .rst_n_i     ( rst_n_i                ),
        .cen_i       ( cen_eff                ),
        .instr_i     ( instr                  ),
        .instr_vld_i ( instr_vld              ),
        .acc_i       ( acc                    ),
        .carry_i     ( carry                  ),
        .dptr_i      ( dptr                   ),
        .p0_i        ( SYNC_P0 ? p0_s : p0_i  ),
        .p1_latch_i  ( p1_o                   ),
        .ram_q_i     ( ram_q                  ),
        .x_din_i     ( x_din_i                ),
        .ram_addr_o  ( ram_addr               ),
        .exec_o      ( exec                   ),
        .exec_vld_o  ( exec_vld               ),
        .xbus_o      ( xbus                   )
    );

    mcu_result u_result (
        .clk           ( clk         ),
        .rst_n_i       ( rst_n_i     ),
        .cen_i         ( cen_eff     ),
        .exec_i        ( exec        ),
        .exec_vld_i    ( exec_vld    ),
        .acc_o         ( acc         ),
        .carry_o       ( carry       ),
        .dptr_o        ( dptr        ),
        .p1_o          ( p1_o        ),
        .ram_we_o      ( ram_we      ),
        .ram_din_o     ( ram_din     ),
        .redirect_o    ( redirect    ),
        .redirect_pc_o ( redirect_pc )
    );

endmodule

// ==== sim/mcu_tb.sv ====
// ****************************************
// testbench for the 8051-subset MCU
// loads each table program in reset, runs
// it and checks P1 writes and MOVX strobes
// ****************************************

module mcu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mcu_pkg::*;

    localparam int NUM_ENTRIES = 5;
    localparam int TIMEOUT_CYC = 400;

    logic              clk;
    logic              rst_n_i;
    logic              cen_i;
    logic [7:0]        p0_i;
    logic [7:0]        x_din_i;
    logic              clk_rom_i;
    logic              prog_we_i;
    logic [ROM_AW-1:0] prog_addr_i;
    logic [7:0]        prog_din_i;
    logic [7:0]        p1_o;
    logic [15:0]       x_addr_o;
    logic [7:0]        x_dout_o;
    logic              x_wr_o;
    logic              x_acc_o;

    // table, program byte 0 in the top bits
    logic [127:0] prog_bits [NUM_ENTRIES];
    logic [7:0]   p0_val    [NUM_ENTRIES];
    logic [7:0]   xdin_val  [NUM_ENTRIES];
    logic [31:0]  p1_bits   [NUM_ENTRIES];
    int           p1_cnt    [NUM_ENTRIES];
    bit           wr_en     [NUM_ENTRIES];
    xbus_t        wr_exp    [NUM_ENTRIES];

    // observed during a run
    logic [7:0] p1_log [$];
    logic [7:0] last_p1;
    int         wr_count;
    xbus_t      wr_got;
    integer     seed;

    mcu_top #(
        .DIV_CEN ( 1'b0 ),
        .SYNC_P0 ( 1'b1 )
    ) u_dut (
        .clk         ( clk         ),
        .rst_n_i     ( rst_n_i     ),
        .cen_i       ( cen_i       ),
        .p0_i        ( p0_i        ),
        .x_din_i     ( x_din_i     ),
        .clk_rom_i   ( clk_rom_i   ),
        .prog_we_i   ( prog_we_i   ),
        .prog_addr_i ( prog_addr_i ),
        .prog_din_i  ( prog_din_i  ),
        .p1_o        ( p1_o        ),
        .x_addr_o    ( x_addr_o    ),
        .x_dout_o    ( x_dout_o    ),
        .x_wr_o      ( x_wr_o      ),
        .x_acc_o     ( x_acc_o     )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // loader clock, same period, slight phase offset
    initial begin
        clk_rom_i = 1'b0;
        #1;
        forever #4 clk_rom_i = ~clk_rom_i;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %s: got 0x%02h, expected 0x%02h", name, got, exp));
        end
    endtask

    task automatic check_xbus(input string name, input xbus_t got, input xbus_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %s: got 0x%07h, expected 0x%07h (addr,dout,wr,acc)",
                                    name, got, exp));
        end
    endtask

    // one clk, logs P1 changes and write strobes
    task automatic sample_outputs();
        @(negedge clk);
        if (p1_o !== last_p1) begin
            p1_log.push_back(p1_o);
            last_p1 = p1_o;
        end
        if (x_wr_o === 1'b1) begin
            wr_count++;
            wr_got = {x_addr_o, x_dout_o, x_wr_o, x_acc_o};
        end
    endtask

    task automatic wait_p1_change(input int idx);
        int cycles;
        cycles = 0;
        while (p1_log.size() <= idx && cycles < TIMEOUT_CYC) begin
            sample_outputs();
            cycles++;
        end
        if (p1_log.size() <= idx) begin
            stop_on_error($sformatf("timeout: P1 change %0d did not come within %0d cycles",
                                    idx, TIMEOUT_CYC));
        end
    endtask

    task automatic catch_wr_strobe();
        int cycles;
        cycles = 0;
        while (wr_count == 0 && cycles < TIMEOUT_CYC) begin
            sample_outputs();
            cycles++;
        end
        if (wr_count == 0) begin
            stop_on_error("timeout: no external write strobe on x_wr_o");
        end
    endtask

    task automatic fill_table();
        logic [31:0] rnd;
        logic [7:0]  p0_rnd;
        rnd    = $random(seed);
        p0_rnd = rnd[7:0];
        // P1 must move away from its reset value 0xFF
        if (p0_rnd == 8'hFE) begin
            p0_rnd = 8'h3E;
        end
        // MOV A,#5A  ORL #0F  XRL #FF  ANL #3C  MOV P1,A  SJMP $
        prog_bits[0] = 128'h745A_440F_64FF_543C_F590_80FE_0000_0000;
        // (5A|0F)^FF = A0, A0&3C = 20
        p1_bits[0]   = {8'h20, 24'h0};
        p1_cnt[0]    = 1;
        // MOV 30,#F0  MOV A,30  ADD #20  MOV P1,A  ADD A,30  MOV P1,A  SJMP $
        prog_bits[1] = 128'h7530_F0E5_3024_20F5_9025_30F5_9080_FE00;
        // F0+20 = 110 so A=10, then 10+F0 = 100 so A=00
        p1_bits[1]   = {8'h10, 8'h00, 16'h0};
        p1_cnt[1]    = 2;
        // MOV A,P0  INC A  MOV P1,A  SJMP $
        prog_bits[2] = 128'hE580_04F5_9080_FE00_0000_0000_0000_0000;
        p1_bits[2]   = {p0_rnd + 8'd1, 24'h0};
        p1_cnt[2]    = 1;
        // A=3, loop ADD #FF / MOV P1,A / JNZ -6, JZ +3 over MOV P1,#55, MOVX, SJMP $
        prog_bits[3] = 128'h7403_24FF_F590_70FA_6003_7590_55F0_80FE;
        p1_bits[3]   = {8'h02, 8'h01, 8'h00, 8'h00};
        p1_cnt[3]    = 3;
        // MOV A,#77  MOV DPTR,#1234  MOVX @DPTR,A  MOVX A,@DPTR  MOV P1,A  SJMP $
        prog_bits[4] = 128'h7477_9012_34F0_E0F5_9080_FE00_0000_0000;
        p1_bits[4]   = {8'hC3, 24'h0};
        p1_cnt[4]    = 1;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            p0_val[e]   = 8'h00;
            xdin_val[e] = 8'h00;
            wr_en[e]    = 1'b0;
            wr_exp[e]   = '0;
        end
        p0_val[2]   = p0_rnd;
        xdin_val[4] = 8'hC3;
        // DPTR still at reset value, A counted down to 0
        wr_en[3]    = 1'b1;
        wr_exp[3]   = {16'h0000, 8'h00, 1'b1, 1'b1};
        wr_en[4]    = 1'b1;
        wr_exp[4]   = {16'h1234, 8'h77, 1'b1, 1'b1};
    endtask

    // whole 16 bytes so no stale bytes remain
    task automatic load_program(input int e);
        for (int i = 0; i < 16; i++) begin
            @(negedge clk_rom_i);
            prog_we_i   = 1'b1;
            prog_addr_i = ROM_AW'(i);
            prog_din_i  = prog_bits[e][127-8*i -: 8];
        end
        @(negedge clk_rom_i);
        prog_we_i = 1'b0;
    endtask

    task automatic run_entry(input int e);
        @(negedge clk);
        rst_n_i = 1'b0;
        p0_i    = p0_val[e];
        x_din_i = xdin_val[e];
        load_program(e);
        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        // state right after reset
        check_byte("p1_o after reset", p1_o, 8'hFF);
        check_byte("x_wr_o after reset", {7'b0, x_wr_o}, 8'h00);
        check_byte("x_acc_o after reset", {7'b0, x_acc_o}, 8'h00);
        p1_log.delete();
        last_p1  = p1_o;
        wr_count = 0;
        wr_got   = '0;
        for (int k = 0; k < p1_cnt[e]; k++) begin
            wait_p1_change(k);
        end
        if (wr_en[e]) begin
            catch_wr_strobe();
        end
        for (int k = 0; k < p1_cnt[e]; k++) begin
            check_byte($sformatf("p1_o write %0d of entry %0d", k, e), p1_log[k],
                       p1_bits[e][31-8*k -: 8]);
        end
        // a skipped P1 write would show up as an extra change
        check_byte("p1_o change count", 8'(p1_log.size()), 8'(p1_cnt[e]));
        check_byte("x_wr_o strobe count", 8'(wr_count), {7'b0, wr_en[e]});
        if (wr_en[e]) begin
            check_xbus("external write", wr_got, wr_exp[e]);
        end
    endtask

    initial begin
        rst_n_i     = 1'b0;
        cen_i       = 1'b1;
        p0_i        = 8'h00;
        x_din_i     = 8'h00;
        prog_we_i   = 1'b0;
        prog_addr_i = '0;
        prog_din_i  = 8'h00;
        seed        = 32'h6fdb_8392;
        fill_table();
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            run_entry(e);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/mcu_pkg.sv
rtl/mcu_prog_rom.sv
rtl/mcu_iram.sv
rtl/mcu_decode.sv
rtl/mcu_execute.sv
rtl/mcu_result.sv
rtl/mcu_top.sv
sim/mcu_tb.sv
